//--- hw/lsu_pkg.sv
package lsu_pkg;

   // **************************************************
   // Memory map
   // **************************************************

   localparam logic [31:0] DCCM_BASE = 32'hF004_0000;  // DCCM start address

   localparam int DCCM_ADDR_BITS = 16;                  // Byte address bits, 64 KB
   localparam int DCCM_WORD_BITS = DCCM_ADDR_BITS - 2;  // Word address bits

   // **************************************************
   // Store buffer sizing
   // **************************************************

   localparam int SB_DEPTH    = 4;  // Entries
   localparam int SB_PTR_BITS = 2;  // log2 of SB_DEPTH

   // **************************************************
   // Shared types
   // **************************************************

   // Access size from decode
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_t;

   // Error cause reported in M
   typedef enum logic [1:0] {
      ERR_NONE     = 2'd0,
      ERR_MISALIGN = 2'd1,  // Half or word not naturally aligned
      ERR_RANGE    = 2'd2   // Address outside the DCCM window
   } err_cause_t;

   // Word address inside the DCCM
   typedef logic [DCCM_WORD_BITS-1:0] word_addr_t;

   // One enable per byte lane of a 32-bit word
   typedef logic [3:0] byteen_t;

endpackage

//--- hw/lsu_addr_gen.sv
`timescale 1ns/1ps

// D-stage address generation and access checks
module lsu_addr_gen
   import lsu_pkg::*;
(
   input  logic        dec_valid_d,   // Instruction strobe from decode
   input  logic        dec_load_d,    // Load
   input  logic        dec_store_d,   // Store
   input  size_t       dec_size_d,    // Byte, half or word
   input  logic [31:0] rs1_d,         // Base register
   input  logic [11:0] offset_d,      // Immediate offset
   input  logic [31:0] rs2_d,         // Store data

   output logic [31:0] addr_d,        // Full effective address
   output word_addr_t  word_addr_d,   // DCCM word address
   output byteen_t     byteen_d,      // Lanes touched by the access
   output logic [31:0] st_data_d,     // Store data in its lanes
   output err_cause_t  err_cause_d,   // Range or alignment error
   output logic        dccm_rden,     // DCCM read request
   output word_addr_t  dccm_rd_addr   // DCCM read word address
);

   logic [31:0] offset_sext;  // Sign-extended immediate
   logic        access_d;     // Valid load or store in D
   logic        in_dccm_d;    // Address hits the DCCM window
   logic        misalign_d;   // Not naturally aligned for its size
   byteen_t     size_mask;    // Lane mask before the shift

   // Effective address
   assign offset_sext = {{20{offset_d[11]}}, offset_d};
   assign addr_d      = rs1_d + offset_sext;

   assign access_d = dec_valid_d & (dec_load_d | dec_store_d);

   // Upper bits must match the DCCM base
   assign in_dccm_d = (addr_d[31:DCCM_ADDR_BITS] == DCCM_BASE[31:DCCM_ADDR_BITS]);

   // **************************************************
   // Size decode
   // **************************************************

   always_comb begin
      case (dec_size_d)
         SZ_HALF: begin
            misalign_d = addr_d[0];
            size_mask  = 4'b0011;
         end
         SZ_WORD: begin
            misalign_d = |addr_d[1:0];
            size_mask  = 4'b1111;
         end
         default: begin  // Bytes are always aligned
            misalign_d = 1'b0;
            size_mask  = 4'b0001;
         end
      endcase
   end

   // Range error wins over misalignment
   always_comb begin
      if (!access_d) begin
         err_cause_d = ERR_NONE;
      end else if (!in_dccm_d) begin
         err_cause_d = ERR_RANGE;
      end else if (misalign_d) begin
         err_cause_d = ERR_MISALIGN;
      end else begin
         err_cause_d = ERR_NONE;
      end
   end

   // Lane alignment of enables and store data
   assign byteen_d    = size_mask << addr_d[1:0];
   assign st_data_d   = rs2_d << {addr_d[1:0], 3'b000};  // Byte offset times 8
   assign word_addr_d = addr_d[DCCM_ADDR_BITS-1:2];

   // Only clean loads read the DCCM
   assign dccm_rden    = access_d & dec_load_d & (err_cause_d == ERR_NONE);
   assign dccm_rd_addr = word_addr_d;

endmodule

//--- hw/lsu_pipe.sv
`timescale 1ns/1ps

// M and R stage registers of the load/store pipe
module lsu_pipe
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        flush_r,            // Kills the instruction in R
   input  logic        dec_valid_d,
   input  logic        dec_load_d,
   input  logic        dec_store_d,
   input  size_t       dec_size_d,
   input  logic        dec_unsign_d,
   input  logic [31:0] addr_d,
   input  word_addr_t  word_addr_d,
   input  byteen_t     byteen_d,
   input  logic [31:0] st_data_d,
   input  err_cause_t  err_cause_d,

   output logic        load_m,             // Load in M, error or not
   output size_t       size_m,
   output logic        unsign_m,
   output logic [1:0]  byte_off_m,         // Low address bits for extraction
   output byteen_t     byteen_m,
   output word_addr_t  word_addr_m,
   output logic        lsu_load_valid_m,   // Load result strobe
   output logic        lsu_error_m,        // Access error strobe
   output err_cause_t  lsu_error_cause_m,
   output logic        store_m_valid,      // Clean store in M
   output logic        store_r_valid,      // Clean store in R
   output word_addr_t  r_word_addr,
   output byteen_t     r_byteen,
   output logic [31:0] r_data,
   output logic        sb_wr,              // Store buffer push
   output logic        lsu_busy_pipe       // Something valid in M or R
);

   logic        store_m;    // Store in M, error or not
   err_cause_t  err_m;
   logic [31:0] st_data_m;
   logic        valid_r;    // Any access in R

   // **************************************************
   // Control flops
   // **************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         load_m        <= 1'b0;
         store_m       <= 1'b0;
         err_m         <= ERR_NONE;
         valid_r       <= 1'b0;
         store_r_valid <= 1'b0;
      end else begin
         load_m        <= dec_valid_d & dec_load_d;
         store_m       <= dec_valid_d & dec_store_d;
         err_m         <= err_cause_d;     // Already ERR_NONE for non-accesses
         valid_r       <= load_m | store_m;
         store_r_valid <= store_m_valid;   // Errored stores stop in M
      end
   end

   // Payload follows the valid bits
   always_ff @(posedge clk) begin
      size_m      <= dec_size_d;
      unsign_m    <= dec_unsign_d;
      byte_off_m  <= addr_d[1:0];
      byteen_m    <= byteen_d;
      word_addr_m <= word_addr_d;
      st_data_m   <= st_data_d;
      r_word_addr <= word_addr_m;  // M to R
      r_byteen    <= byteen_m;
      r_data      <= st_data_m;
   end

   // M-stage strobes
   assign lsu_error_m       = (err_m != ERR_NONE);
   assign lsu_error_cause_m = err_m;
   assign lsu_load_valid_m  = load_m & ~lsu_error_m;
   assign store_m_valid     = store_m & ~lsu_error_m;

   // Commit to the store buffer unless flushed
   assign sb_wr = store_r_valid & ~flush_r;

   assign lsu_busy_pipe = load_m | store_m | valid_r;

endmodule

//--- hw/lsu_stbuf.sv
`timescale 1ns/1ps

// Store buffer between commit and the DCCM write port
module lsu_stbuf
   import lsu_pkg::*;
(
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 sb_wr,           // Committed store from R
   input  word_addr_t           r_word_addr,
   input  byteen_t              r_byteen,
   input  logic [31:0]          r_data,
   input  word_addr_t           word_addr_m,     // Load address in M

   output logic [SB_PTR_BITS:0] sb_count,        // Occupancy
   output byteen_t              fwd_byteen,      // Lanes with forwarded data
   output logic [31:0]          fwd_data,
   output logic                 dccm_wren,       // Drain strobe
   output word_addr_t           dccm_wr_addr,
   output logic [31:0]          dccm_wr_data,
   output byteen_t              dccm_wr_byteen
);

   // Entry storage
   word_addr_t  sb_addr [SB_DEPTH];
   logic [31:0] sb_data [SB_DEPTH];
   byteen_t     sb_be   [SB_DEPTH];

   logic [SB_PTR_BITS-1:0] wr_ptr;    // Next free slot
   logic [SB_PTR_BITS-1:0] rd_ptr;    // Oldest entry
   logic                   sb_drain;  // Oldest entry leaves this cycle

   // Drain whenever something is held
   assign sb_drain = (sb_count != '0);

   // **************************************************
   // Pointers and count
   // **************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         sb_count <= '0;
      end else begin
         if (sb_wr) begin
            wr_ptr <= wr_ptr + 1'b1;  // Wraps at SB_DEPTH
         end
         if (sb_drain) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({sb_wr, sb_drain})
            2'b10:   sb_count <= sb_count + 1'b1;
            2'b01:   sb_count <= sb_count - 1'b1;
            default: sb_count <= sb_count;  // Push and pop cancel
         endcase
      end
   end

   // Entry write
   always_ff @(posedge clk) begin
      if (sb_wr) begin
         sb_addr[wr_ptr] <= r_word_addr;
         sb_data[wr_ptr] <= r_data;
         sb_be[wr_ptr]   <= r_byteen;
      end
   end

   // DCCM write port
   assign dccm_wren      = sb_drain;
   assign dccm_wr_addr   = sb_addr[rd_ptr];
   assign dccm_wr_data   = sb_data[rd_ptr];
   assign dccm_wr_byteen = sb_be[rd_ptr];

   // **************************************************
   // Forwarding to the M-stage load
   // **************************************************

   // Walk oldest to youngest so younger bytes overwrite older ones
   always_comb begin : fwd_merge
      logic [SB_PTR_BITS-1:0] idx;

      fwd_byteen = '0;
      fwd_data   = '0;
      idx        = rd_ptr;
      for (int k = 0; k < SB_DEPTH; k++) begin
         idx = rd_ptr + SB_PTR_BITS'(k);
         if (((SB_PTR_BITS+1)'(k) < sb_count) && (sb_addr[idx] == word_addr_m)) begin
            for (int b = 0; b < $bits(byteen_t); b++) begin
               if (sb_be[idx][b]) begin
                  fwd_byteen[b]      = 1'b1;
                  fwd_data[8*b +: 8] = sb_data[idx][8*b +: 8];
               end
            end
         end
      end
      // Committing R store is the youngest of all
      if (sb_wr && (r_word_addr == word_addr_m)) begin
         for (int b = 0; b < $bits(byteen_t); b++) begin
            if (r_byteen[b]) begin
               fwd_byteen[b]      = 1'b1;
               fwd_data[8*b +: 8] = r_data[8*b +: 8];
            end
         end
      end
   end

endmodule

//--- hw/lsu_load_align.sv
`timescale 1ns/1ps

// M-stage load data merge and extraction
module lsu_load_align
   import lsu_pkg::*;
(
   input  logic        load_m,         // Load in M
   input  size_t       size_m,
   input  logic        unsign_m,       // Zero-extend when set
   input  logic [1:0]  byte_off_m,     // Byte offset in the word
   input  byteen_t     fwd_byteen,     // Lanes supplied by stores
   input  logic [31:0] fwd_data,
   input  logic [31:0] dccm_rd_data,   // Word read in D

   output logic [31:0] lsu_result_m
);

   logic [31:0] merged;   // Memory word with store bytes on top
   logic [31:0] shifted;  // Access moved down to bit 0
   logic [31:0] ext;      // Extended result

   // **************************************************
   // Lane merge
   // **************************************************

   always_comb begin
      for (int b = 0; b < $bits(byteen_t); b++) begin
         if (fwd_byteen[b]) begin
            merged[8*b +: 8] = fwd_data[8*b +: 8];
         end else begin
            merged[8*b +: 8] = dccm_rd_data[8*b +: 8];
         end
      end
   end

   assign shifted = merged >> {byte_off_m, 3'b000};

   // Sign bit is masked off for unsigned loads
   always_comb begin
      case (size_m)
         SZ_BYTE: ext = {{24{~unsign_m & shifted[7]}}, shifted[7:0]};
         SZ_HALF: ext = {{16{~unsign_m & shifted[15]}}, shifted[15:0]};
         default: ext = shifted;  // Full word
      endcase
   end

   // Quiet bus when no load is in M
   assign lsu_result_m = load_m ? ext : '0;

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps

// Load/store unit top, D -> M -> R
module lsu_top
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        flush_r,               // Kill R instruction
   input  logic        dec_valid_d,
   input  logic        dec_load_d,
   input  logic        dec_store_d,
   input  size_t       dec_size_d,
   input  logic        dec_unsign_d,
   input  logic [31:0] rs1_d,
   input  logic [11:0] offset_d,
   input  logic [31:0] rs2_d,

   output logic [31:0] lsu_result_m,
   output logic        lsu_load_valid_m,
   output logic        lsu_error_m,
   output err_cause_t  lsu_error_cause_m,
   output logic        lsu_store_stall_any,   // Hold stores in decode
   output logic        lsu_idle_any,          // Pipe and buffer empty

   output logic        dccm_rden,
   output word_addr_t  dccm_rd_addr,
   input  logic [31:0] dccm_rd_data,
   output logic        dccm_wren,
   output word_addr_t  dccm_wr_addr,
   output logic [31:0] dccm_wr_data,
   output byteen_t     dccm_wr_byteen
);

   // D stage
   logic [31:0]          addr_d;
   word_addr_t           word_addr_d;
   byteen_t              byteen_d;
   logic [31:0]          st_data_d;
   err_cause_t           err_cause_d;
   // M and R stages
   logic                 load_m;
   size_t                size_m;
   logic                 unsign_m;
   logic [1:0]           byte_off_m;
   byteen_t              byteen_m;
   word_addr_t           word_addr_m;
   logic                 store_m_valid;
   logic                 store_r_valid;
   word_addr_t           r_word_addr;
   byteen_t              r_byteen;
   logic [31:0]          r_data;
   logic                 sb_wr;
   logic                 lsu_busy_pipe;
   // Store buffer
   logic [SB_PTR_BITS:0]   sb_count;
   byteen_t                fwd_byteen;
   byteen_t                fwd_byteen_m;  // Only lanes the load reads
   logic [31:0]            fwd_data;
   logic [SB_PTR_BITS+1:0] sb_pending;    // Buffered plus in-flight stores

   lsu_addr_gen u_addr_gen (
      .dec_valid_d (dec_valid_d),
      .dec_load_d  (dec_load_d),
      .dec_store_d (dec_store_d),
      .dec_size_d  (dec_size_d),
      .rs1_d       (rs1_d),
      .offset_d    (offset_d),
      .rs2_d       (rs2_d),
      .addr_d      (addr_d),
      .word_addr_d (word_addr_d),
      .byteen_d    (byteen_d),
      .st_data_d   (st_data_d),
      .err_cause_d (err_cause_d),
      .dccm_rden   (dccm_rden),
      .dccm_rd_addr(dccm_rd_addr)
   );

   lsu_pipe u_pipe (
      .clk              (clk),
      .reset            (reset),
      .flush_r          (flush_r),
      .dec_valid_d      (dec_valid_d),
      .dec_load_d       (dec_load_d),
      .dec_store_d      (dec_store_d),
      .dec_size_d       (dec_size_d),
      .dec_unsign_d     (dec_unsign_d),
      .addr_d           (addr_d),
      .word_addr_d      (word_addr_d),
      .byteen_d         (byteen_d),
      .st_data_d        (st_data_d),
      .err_cause_d      (err_cause_d),
      .load_m           (load_m),
      .size_m           (size_m),
      .unsign_m         (unsign_m),
      .byte_off_m       (byte_off_m),
      .byteen_m         (byteen_m),
      .word_addr_m      (word_addr_m),
      .lsu_load_valid_m (lsu_load_valid_m),
      .lsu_error_m      (lsu_error_m),
      .lsu_error_cause_m(lsu_error_cause_m),
      .store_m_valid    (store_m_valid),
      .store_r_valid    (store_r_valid),
      .r_word_addr      (r_word_addr),
      .r_byteen         (r_byteen),
      .r_data           (r_data),
      .sb_wr            (sb_wr),
      .lsu_busy_pipe    (lsu_busy_pipe)
   );

   lsu_stbuf u_stbuf (
      .clk           (clk),
      .reset         (reset),
      .sb_wr         (sb_wr),
      .r_word_addr   (r_word_addr),
      .r_byteen      (r_byteen),
      .r_data        (r_data),
      .word_addr_m   (word_addr_m),
      .sb_count      (sb_count),
      .fwd_byteen    (fwd_byteen),
      .fwd_data      (fwd_data),
      .dccm_wren     (dccm_wren),
      .dccm_wr_addr  (dccm_wr_addr),
      .dccm_wr_data  (dccm_wr_data),
      .dccm_wr_byteen(dccm_wr_byteen)
   );

   assign fwd_byteen_m = fwd_byteen & byteen_m;

   lsu_load_align u_load_align (
      .load_m      (load_m),
      .size_m      (size_m),
      .unsign_m    (unsign_m),
      .byte_off_m  (byte_off_m),
      .fwd_byteen  (fwd_byteen_m),
      .fwd_data    (fwd_data),
      .dccm_rd_data(dccm_rd_data),
      .lsu_result_m(lsu_result_m)
   );

   // **************************************************
   // Stall and idle
   // **************************************************

   // Stores already past D still need a slot
   assign sb_pending          = sb_count + store_m_valid + store_r_valid;
   assign lsu_store_stall_any = (sb_pending >= SB_DEPTH);

   assign lsu_idle_any = ~lsu_busy_pipe & (sb_count == '0);  // Nothing left to write

endmodule

//--- bench/dccm_model.sv
`timescale 1ns/1ps

// Byte-enabled DCCM with one-cycle read latency
module dccm_model
   import lsu_pkg::*;
(
   input  logic        clk,
   input  logic        rden,        // Read request from D
   input  word_addr_t  rd_addr,
   output logic [31:0] rd_data,     // Valid in the cycle after rden
   input  logic        wren,        // Store buffer drain
   input  word_addr_t  wr_addr,
   input  logic [31:0] wr_data,
   input  byteen_t     wr_byteen
);

   logic [31:0] mem [1 << DCCM_WORD_BITS];

   // Every word starts with a pattern built from its own address
   initial begin
      for (int i = 0; i < (1 << DCCM_WORD_BITS); i++) begin
         mem[i] = {2'b10, 14'(i), ~14'(i), 2'b01};
      end
   end

   // Write-first: a same-word read sees the bytes written this cycle
   always @(posedge clk) begin
      for (int b = 0; b < 4; b++) begin
         if (wren && wr_byteen[b]) begin
            mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
         end
         if (rden) begin
            if (wren && wr_byteen[b] && (wr_addr == rd_addr)) begin
               rd_data[8*b +: 8] <= wr_data[8*b +: 8];  // New byte wins
            end else begin
               rd_data[8*b +: 8] <= mem[rd_addr][8*b +: 8];
            end
         end
      end
   end

endmodule

//--- bench/tb_lsu.sv
`timescale 1ns/1ps

module tb_lsu
   import lsu_pkg::*;
();

   localparam int          TIMEOUT = 50;                   // Cycles per wait
   localparam int          NWORDS  = 1 << DCCM_WORD_BITS;
   localparam logic [31:0] A0      = DCCM_BASE + 32'h100;  // Sub-word area
   localparam logic [31:0] A1      = DCCM_BASE + 32'h200;  // Store burst area

   typedef enum logic [1:0] {OP_NOP, OP_LD, OP_ST} op_kind_t;

   // One row of the operation table
   typedef struct packed {
      op_kind_t    kind;
      size_t       size;
      logic        unsign;
      logic [31:0] rs1;
      logic [11:0] offset;
      logic [31:0] data;    // Store data, low bytes used
      logic        flush;   // Raise flush_r in the R cycle
      logic [31:0] exp;     // Load result
      err_cause_t  err;
   } op_t;

   logic        clk, reset, flush_r;
   logic        dec_valid_d, dec_load_d, dec_store_d, dec_unsign_d;
   size_t       dec_size_d;
   logic [31:0] rs1_d, rs2_d;
   logic [11:0] offset_d;
   logic [31:0] lsu_result_m;
   logic        lsu_load_valid_m, lsu_error_m, lsu_store_stall_any, lsu_idle_any;
   err_cause_t  lsu_error_cause_m;
   logic        dccm_rden, dccm_wren;
   word_addr_t  dccm_rd_addr, dccm_wr_addr;
   logic [31:0] dccm_rd_data, dccm_wr_data;
   byteen_t     dccm_wr_byteen;

   op_t         ops [$];              // Operation table
   op_t         d_op, m_op, r_op;     // What sits in each stage
   int          occ;                  // Expected store buffer count
   logic [31:0] ref_mem [NWORDS];     // Reference memory
   int          errors, checks;

   lsu_top u_dut (.*);

   dccm_model u_mem (
      .clk      (clk),
      .rden     (dccm_rden),
      .rd_addr  (dccm_rd_addr),
      .rd_data  (dccm_rd_data),
      .wren     (dccm_wren),
      .wr_addr  (dccm_wr_addr),
      .wr_data  (dccm_wr_data),
      .wr_byteen(dccm_wr_byteen)
   );

   always #20 clk = ~clk;  // 40 ns period

   // **************************************************
   // Helpers
   // **************************************************

   function automatic logic [31:0] fill_word(input int i);
      logic [13:0] w;
      w = i[13:0];
      return {2'b10, w, ~w, 2'b01};  // Same start pattern as the DCCM
   endfunction

   function automatic op_t nop_op();
      op_t o;
      o      = '0;
      o.kind = OP_NOP;
      return o;
   endfunction

   // Base plus sign-extended offset of a table row
   function automatic logic [31:0] eff_addr(input op_t o);
      return o.rs1 + {{20{o.offset[11]}}, o.offset};
   endfunction

   task automatic add_op(input op_kind_t kind, input size_t size, input logic unsign,
                         input logic [31:0] rs1, input logic [11:0] offset,
                         input logic [31:0] data, input logic flush,
                         input logic [31:0] exp, input err_cause_t err);
      op_t o;
      o = '{kind, size, unsign, rs1, offset, data, flush, exp, err};
      ops.push_back(o);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      checks++;
      if (actual !== expected) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, expected, actual);
      end
   endtask

   task automatic end_run();
      $display("errors: %0d of %0d checks", errors, checks);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   endtask

   // Applies the lanes of a committed store to the reference memory
   task automatic commit_store(input op_t o);
      logic [31:0] addr;
      logic [3:0]  lanes;
      int          wa;
      addr = eff_addr(o);
      wa   = addr[DCCM_ADDR_BITS-1:2];
      case (o.size)
         SZ_BYTE: lanes = 4'b0001;
         SZ_HALF: lanes = 4'b0011;
         default: lanes = 4'b1111;
      endcase
      for (int b = 0; b < 4; b++) begin
         if (lanes[b]) begin
            ref_mem[wa][8*(b + addr[1:0]) +: 8] = o.data[8*b +: 8];
         end
      end
   endtask

   task automatic check_outputs();
      logic        m_ld, m_st, r_st, d_ld;
      logic [31:0] d_addr;
      m_ld   = (m_op.kind == OP_LD) && (m_op.err == ERR_NONE);
      m_st   = (m_op.kind == OP_ST) && (m_op.err == ERR_NONE);
      r_st   = (r_op.kind == OP_ST) && (r_op.err == ERR_NONE);
      d_ld   = (d_op.kind == OP_LD) && (d_op.err == ERR_NONE);
      d_addr = eff_addr(d_op);
      check_value("lsu_load_valid_m", lsu_load_valid_m, m_ld);
      check_value("lsu_error_m", lsu_error_m, m_op.err != ERR_NONE);
      check_value("lsu_error_cause_m", lsu_error_cause_m, m_op.err);
      if (m_ld) begin
         check_value("lsu_result_m", lsu_result_m, m_op.exp);
      end
      check_value("dccm_rden", dccm_rden, d_ld);
      if (d_ld) begin
         check_value("dccm_rd_addr", dccm_rd_addr, d_addr[DCCM_ADDR_BITS-1:2]);
      end
      check_value("dccm_wren", dccm_wren, occ != 0);  // Drains while not empty
      check_value("lsu_store_stall_any", lsu_store_stall_any,
                  (occ + m_st + r_st) >= SB_DEPTH);  // Flushed R store still counts
      check_value("lsu_idle_any", lsu_idle_any,
                  (m_op.kind == OP_NOP) && (r_op.kind == OP_NOP) && (occ == 0));
   endtask

   // One clock cycle: drive D, then check M late in the cycle
   task automatic step(input op_t op, output bit issued);
      op_t  cur;
      logic push;
      @(posedge clk);
      push = (r_op.kind == OP_ST) && (r_op.err == ERR_NONE) && !r_op.flush;
      occ  = occ + int'(push) - int'(occ != 0);  // Drain one per cycle
      r_op = m_op;
      m_op = d_op;
      #2;
      issued       = !((op.kind == OP_ST) && lsu_store_stall_any);  // Store held back
      cur          = issued ? op : nop_op();
      dec_valid_d  = (cur.kind != OP_NOP);
      dec_load_d   = (cur.kind == OP_LD);
      dec_store_d  = (cur.kind == OP_ST);
      dec_size_d   = cur.size;
      dec_unsign_d = cur.unsign;
      rs1_d        = cur.rs1;
      offset_d     = cur.offset;
      rs2_d        = cur.data;
      flush_r      = r_op.flush;
      if ((cur.kind == OP_ST) && (cur.err == ERR_NONE) && !cur.flush) begin
         commit_store(cur);
      end
      d_op = cur;
      #20;
      check_outputs();
   endtask

   // **************************************************
   // Operation table
   // **************************************************

   task automatic build_table();
      // Word round trip through R and buffer forwarding
      add_op(OP_ST, SZ_WORD, 0, A0, 12'h000, 32'h1122_3344, 0, 0, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h000, 0, 0, 32'h1122_3344, ERR_NONE);
      add_op(OP_ST, SZ_WORD, 0, A0, 12'h004, 32'hA5A5_5A5A, 0, 0, ERR_NONE);
      add_op(OP_NOP, SZ_WORD, 0, 0, 12'h000, 0, 0, 0, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h004, 0, 0, 32'hA5A5_5A5A, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0 + 8, 12'hFFC, 0, 0, 32'hA5A5_5A5A, ERR_NONE);
      // Sub-word loads at each offset
      add_op(OP_LD, SZ_BYTE, 0, A0, 12'h000, 0, 0, 32'h0000_0044, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 1, A0, 12'h001, 0, 0, 32'h0000_0033, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 0, A0, 12'h002, 0, 0, 32'h0000_0022, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 0, A0, 12'h003, 0, 0, 32'h0000_0011, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 0, A0, 12'h006, 0, 0, 32'hFFFF_FFA5, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 1, A0, 12'h007, 0, 0, 32'h0000_00A5, ERR_NONE);
      add_op(OP_LD, SZ_HALF, 0, A0, 12'h004, 0, 0, 32'h0000_5A5A, ERR_NONE);
      add_op(OP_LD, SZ_HALF, 0, A0, 12'h006, 0, 0, 32'hFFFF_A5A5, ERR_NONE);
      add_op(OP_LD, SZ_HALF, 1, A0, 12'h006, 0, 0, 32'h0000_A5A5, ERR_NONE);
      add_op(OP_LD, SZ_HALF, 1, A0, 12'h002, 0, 0, 32'h0000_1122, ERR_NONE);
      // Partial stores merge with older bytes
      add_op(OP_ST, SZ_BYTE, 0, A0, 12'h001, 32'h0000_00EE, 0, 0, ERR_NONE);
      add_op(OP_ST, SZ_HALF, 0, A0, 12'h002, 32'h0000_8877, 0, 0, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h000, 0, 0, 32'h8877_EE44, ERR_NONE);
      add_op(OP_LD, SZ_HALF, 0, A0, 12'h002, 0, 0, 32'hFFFF_8877, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 0, A0, 12'h001, 0, 0, 32'hFFFF_FFEE, ERR_NONE);
      add_op(OP_LD, SZ_BYTE, 1, A0, 12'h000, 0, 0, 32'h0000_0044, ERR_NONE);
      // Misaligned and out-of-range accesses write nothing
      add_op(OP_LD, SZ_HALF, 0, A0, 12'h001, 0, 0, 0, ERR_MISALIGN);
      add_op(OP_ST, SZ_WORD, 0, A0, 12'h002, 32'hDEAD_BEEF, 0, 0, ERR_MISALIGN);
      add_op(OP_LD, SZ_WORD, 0, 32'h0000_1000, 12'h000, 0, 0, 0, ERR_RANGE);
      add_op(OP_ST, SZ_WORD, 0, DCCM_BASE + 32'h1_0002, 12'h000, 32'h1, 0, 0, ERR_RANGE);
      add_op(OP_LD, SZ_BYTE, 0, DCCM_BASE, 12'h800, 0, 0, 0, ERR_RANGE);  // Below base
      add_op(OP_ST, SZ_HALF, 0, A0, 12'h003, 32'h0000_FFFF, 0, 0, ERR_MISALIGN);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h000, 0, 0, 32'h8877_EE44, ERR_NONE);
      // Flushed stores never land
      add_op(OP_ST, SZ_WORD, 0, A0, 12'h008, 32'hCAFE_0001, 0, 0, ERR_NONE);
      add_op(OP_ST, SZ_WORD, 0, A0, 12'h008, 32'h0BAD_F00D, 1, 0, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h008, 0, 0, 32'hCAFE_0001, ERR_NONE);
      add_op(OP_ST, SZ_BYTE, 0, A0, 12'h009, 32'h0000_0077, 1, 0, ERR_NONE);
      add_op(OP_NOP, SZ_WORD, 0, 0, 12'h000, 0, 0, 0, ERR_NONE);
      add_op(OP_LD, SZ_WORD, 0, A0, 12'h008, 0, 0, 32'hCAFE_0001, ERR_NONE);
      // Back-to-back store burst, then read back
      for (int i = 0; i < 6; i++) begin
         add_op(OP_ST, SZ_WORD, 0, A1, 12'(4 * i), 32'h1000_0001 * (i + 1), 0, 0, ERR_NONE);
      end
      for (int i = 0; i < 6; i++) begin
         add_op(OP_LD, SZ_WORD, 0, A1, 12'(4 * i), 0, 0, 32'h1000_0001 * (i + 1), ERR_NONE);
      end
      add_op(OP_LD, SZ_HALF, 1, A1, 12'h006, 0, 0, 32'h0000_2000, ERR_NONE);
   endtask

   // **************************************************
   // Main sequence
   // **************************************************

   initial begin : main
      bit issued;
      bit stuck;
      int tries;
      clk          = 1'b0;
      reset        = 1'b1;
      flush_r      = 1'b0;
      dec_valid_d  = 1'b0;
      dec_load_d   = 1'b0;
      dec_store_d  = 1'b0;
      dec_size_d   = SZ_WORD;
      dec_unsign_d = 1'b0;
      rs1_d        = '0;
      offset_d     = '0;
      rs2_d        = '0;
      errors       = 0;
      checks       = 0;
      occ          = 0;
      stuck        = 1'b0;
      d_op         = nop_op();
      m_op         = nop_op();
      r_op         = nop_op();
      for (int i = 0; i < NWORDS; i++) begin
         ref_mem[i] = fill_word(i);
      end
      build_table();

      repeat (3) @(posedge clk);  // Reset for 3 cycles
      #2;
      reset = 1'b0;
      #20;
      check_value("lsu_idle_any", lsu_idle_any, 1'b1);
      check_value("lsu_load_valid_m", lsu_load_valid_m, 1'b0);
      check_value("lsu_error_m", lsu_error_m, 1'b0);
      check_value("lsu_store_stall_any", lsu_store_stall_any, 1'b0);
      check_value("dccm_wren", dccm_wren, 1'b0);

      foreach (ops[i]) begin
         if (!stuck) begin
            tries  = 0;
            issued = 1'b0;
            while (!issued && (tries < TIMEOUT)) begin  // Retry while stalled
               step(ops[i], issued);
               tries++;
            end
            if (!issued) begin
               errors++;
               $display("timeout: table row %0d never left decode, store stall stuck high", i);
               stuck = 1'b1;
            end
         end
      end

      // Pipe and buffer must empty out
      if (!stuck) begin
         tries = 0;
         while (!lsu_idle_any && (tries < TIMEOUT)) begin
            step(nop_op(), issued);
            tries++;
         end
         if (!lsu_idle_any) begin
            errors++;
            $display("timeout: unit did not go idle after the last access");
            stuck = 1'b1;
         end
      end

      // Every DCCM word against the reference memory
      if (!stuck) begin
         for (int i = 0; i < NWORDS; i++) begin
            check_value($sformatf("dccm word %0d", i), u_mem.mem[i], ref_mem[i]);
         end
      end
      end_run();
   end

endmodule

//--- all.f
hw/lsu_pkg.sv
hw/lsu_addr_gen.sv
hw/lsu_pipe.sv
hw/lsu_stbuf.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
bench/dccm_model.sv
bench/tb_lsu.sv
